// File: include/soc_bus_consts.svh
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// on-chip RAM window, base aligned to its own size
`define RAM_BASE            64'h0000_0000_8000_0000
`define RAM_WORDS           2048

// PLIC register map, context 0 addresses
`define PLIC_BASE           64'h0000_0000_0c00_0000
`define PLIC_PENDING        64'h0000_0000_0c00_1000
`define PLIC_ENABLE         64'h0000_0000_0c00_2000
`define PLIC_THRESHOLD      64'h0000_0000_0c20_0000
`define PLIC_CLAIM          64'h0000_0000_0c20_0004

// distance from context 0 to context 1
`define PLIC_ENABLE_STRIDE  64'h0000_0000_0000_0080
`define PLIC_CTX_STRIDE     64'h0000_0000_0000_1000

// source ids run from 1 to NUM_SOURCES, id 0 means none
`define NUM_SOURCES         5
`define NUM_CTX             2
`define PRIO_W              3

// machine timer
`define MTIME_ADDR          64'h0000_0000_0200_bff8
`define MTIMECMP_ADDR       64'h0000_0000_0200_4000
`define MTIMECMP_RESET      64'h0000_0000_8000_0000

// flush addresses, acknowledged only
`define TLB_ADDR            64'h0000_0000_1000_1000
`define CACHEI_ADDR         64'h0000_0000_1000_1008

`endif

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // load/store width, bit 2 marks the zero-extending loads
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        ls_type_e    ls_type;
        logic        read;
        logic        write;
    } bus_req_t;

    // one-hot region plus the decoded PLIC context and priority id
    typedef struct packed {
        logic       ram;
        logic       plic_prio;
        logic       plic_pend;
        logic       plic_en;
        logic       plic_thr;
        logic       plic_claim;
        logic       mtime;
        logic       mtimecmp;
        logic       ack_only;
        logic       unmapped;
        logic       ctx;
        logic [4:0] prio_id;
    } region_sel_t;

    typedef struct packed {
        logic        en_wr;
        logic        thr_wr;
        logic        claim_rd;
        logic [31:0] data;
    } plic_wr_t;

endpackage

// File: hdl/bus_decoder.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module bus_decoder (
    input  logic                                   CLOCK_50,
    input  logic                                   KEY0,
    input  soc_bus_pkg::bus_req_t                  req,
    output soc_bus_pkg::bus_req_t                  busy_req,
    output soc_bus_pkg::region_sel_t               sel,
    output soc_bus_pkg::plic_wr_t [`NUM_CTX-1:0]   ctx_wr,
    output logic                                   active
);

    soc_bus_pkg::region_sel_t dec;
    logic [63:0]              a;
    logic                     pulse;
    logic                     extra_step;

    assign a     = req.addr;
    assign pulse = req.read || req.write;

    always_comb begin
        dec            = '0;
        dec.ram        = (a >= `RAM_BASE) && (a < `RAM_BASE + 64'(`RAM_WORDS * 4));
        // 32 priority words, one per id
        dec.plic_prio  = (a >= `PLIC_BASE) && (a < `PLIC_BASE + 64'h80);
        dec.plic_pend  = (a == `PLIC_PENDING);
        dec.plic_en    = (a == `PLIC_ENABLE) || (a == `PLIC_ENABLE + `PLIC_ENABLE_STRIDE);
        dec.plic_thr   = (a == `PLIC_THRESHOLD) || (a == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE);
        dec.plic_claim = (a == `PLIC_CLAIM) || (a == `PLIC_CLAIM + `PLIC_CTX_STRIDE);
        dec.mtime      = (a == `MTIME_ADDR);
        dec.mtimecmp   = (a == `MTIMECMP_ADDR);
        dec.ack_only   = (a == `TLB_ADDR) || (a == `CACHEI_ADDR);
        dec.unmapped   = !(dec.ram || dec.plic_prio || dec.plic_pend || dec.plic_en ||
                           dec.plic_thr || dec.plic_claim || dec.mtime || dec.mtimecmp ||
                           dec.ack_only);
        // context 1 sits one stride above context 0
        dec.ctx        = (a == `PLIC_ENABLE + `PLIC_ENABLE_STRIDE) ||
                         (a == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE) ||
                         (a == `PLIC_CLAIM + `PLIC_CTX_STRIDE);
        dec.prio_id    = a[6:2];
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy_req   <= '0;
            sel        <= '0;
            ctx_wr     <= '0;
            active     <= 1'b0;
            extra_step <= 1'b0;
        end else begin
            // strobes follow the pulse, so they last one cycle
            for (int c = 0; c < `NUM_CTX; c++) begin
                ctx_wr[c].en_wr    <= req.write && dec.plic_en && (dec.ctx == 1'(c));
                ctx_wr[c].thr_wr   <= req.write && dec.plic_thr && (dec.ctx == 1'(c));
                ctx_wr[c].claim_rd <= req.read && dec.plic_claim && (dec.ctx == 1'(c));
                ctx_wr[c].data     <= req.wdata[31:0];
            end
            if (pulse) begin
                busy_req   <= req;
                sel        <= dec;
                active     <= 1'b1;
                // RAM doubleword needs a second step
                extra_step <= dec.ram && (req.ls_type == soc_bus_pkg::LS_D);
            end else if (extra_step) begin
                extra_step <= 1'b0;
            end else begin
                active <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/ram_port.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module ram_port (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::bus_req_t busy_req,
    input  logic                  sel_ram,
    input  logic                  active,
    output logic [63:0]           rdata,
    output logic                  last_step
);

    localparam int AW = $clog2(`RAM_WORDS);

    logic [31:0]   mem [`RAM_WORDS];
    logic          step;
    logic [31:0]   lo_word;
    logic [AW-1:0] idx;
    logic [1:0]    off;
    logic [31:0]   word;
    logic [31:0]   shifted;
    logic [31:0]   wlane;
    logic [3:0]    be;
    logic          is_double;
    logic          hit;

    // base is size aligned, so the low address bits index the array
    assign off       = busy_req.addr[1:0];
    assign idx       = busy_req.addr[AW+1:2] + AW'(step);
    assign word      = mem[idx];
    assign shifted   = word >> {off, 3'b000};
    assign is_double = (busy_req.ls_type == soc_bus_pkg::LS_D);
    assign hit       = active && sel_ram;
    assign last_step = !is_double || step;

    always_comb begin
        case (busy_req.ls_type)
            soc_bus_pkg::LS_B:  rdata = {{56{shifted[7]}}, shifted[7:0]};
            soc_bus_pkg::LS_H:  rdata = {{48{shifted[15]}}, shifted[15:0]};
            soc_bus_pkg::LS_W:  rdata = {{32{shifted[31]}}, shifted};
            // high word on the second step, low word held from the first
            soc_bus_pkg::LS_D:  rdata = {word, lo_word};
            soc_bus_pkg::LS_BU: rdata = {56'd0, shifted[7:0]};
            soc_bus_pkg::LS_HU: rdata = {48'd0, shifted[15:0]};
            soc_bus_pkg::LS_WU: rdata = {32'd0, shifted};
            default:            rdata = '0;
        endcase
    end

    // byte lanes for stores
    always_comb begin
        case (busy_req.ls_type)
            soc_bus_pkg::LS_B: be = 4'b0001 << off;
            soc_bus_pkg::LS_H: be = 4'b0011 << off;
            default:           be = 4'b1111;
        endcase
        if (step) begin
            wlane = busy_req.wdata[63:32];
        end else begin
            wlane = busy_req.wdata[31:0] << {off, 3'b000};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (hit && busy_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= wlane[8*b +: 8];
                end
            end
        end
        if (hit && busy_req.read && is_double && !step) begin
            lo_word <= word;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step <= 1'b0;
        end else if (hit && is_double) begin
            step <= !step;
        end else begin
            step <= 1'b0;
        end
    end

endmodule

// File: hdl/plic_context.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module plic_context (
    input  logic                                     CLOCK_50,
    input  logic                                     KEY0,
    input  soc_bus_pkg::plic_wr_t                    wr,
    input  logic [31:0]                              pending,
    input  logic [`NUM_SOURCES:1][`PRIO_W-1:0]       prio,
    output logic [31:0]                              enable,
    output logic [`PRIO_W-1:0]                       threshold,
    output logic [31:0]                              claim_id,
    output logic                                     irq
);

    logic [`PRIO_W-1:0] best_prio;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            enable    <= '0;
            threshold <= '0;
        end else begin
            if (wr.en_wr) begin
                enable <= wr.data;
            end
            if (wr.thr_wr) begin
                threshold <= wr.data[`PRIO_W-1:0];
            end
        end
    end

    // strict compare, so a tie keeps the lower id
    always_comb begin
        best_prio = threshold;
        claim_id  = '0;
        for (int i = 1; i <= `NUM_SOURCES; i++) begin
            if (pending[i] && enable[i] && (prio[i] > best_prio)) begin
                best_prio = prio[i];
                claim_id  = 32'(i);
            end
        end
    end

    assign irq = (claim_id != '0);

endmodule

// File: hdl/plic_core.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module plic_core (
    input  logic                                    CLOCK_50,
    input  logic                                    KEY0,
    // bit n is source id n
    input  logic [`NUM_SOURCES:1]                   irq_lines,
    input  soc_bus_pkg::bus_req_t                   busy_req,
    input  soc_bus_pkg::region_sel_t                sel,
    input  soc_bus_pkg::plic_wr_t [`NUM_CTX-1:0]    ctx_wr,
    output logic [31:0]                             pend,
    output logic [`PRIO_W-1:0]                      prio_rd,
    output logic [`NUM_CTX-1:0][31:0]               ctx_enable,
    output logic [`NUM_CTX-1:0][`PRIO_W-1:0]        ctx_threshold,
    output logic [`NUM_CTX-1:0][31:0]               ctx_claim,
    output logic                                    meip,
    output logic                                    seip
);

    logic [`NUM_SOURCES:1][`PRIO_W-1:0] prio_q;
    logic [`NUM_SOURCES:1]              pend_q;
    logic [`NUM_SOURCES:1]              line_q;
    logic [`NUM_SOURCES:1]              line_qq;
    logic [`NUM_SOURCES:1]              clr;
    logic [`NUM_CTX-1:0]                irq_vec;
    logic                               id_ok;

    assign id_ok   = (sel.prio_id != 5'd0) && (sel.prio_id <= 5'(`NUM_SOURCES));
    assign prio_rd = id_ok ? prio_q[sel.prio_id] : '0;
    assign pend    = {{(31 - `NUM_SOURCES){1'b0}}, pend_q, 1'b0};

    // a claim read drops the id it returns
    always_comb begin
        clr = '0;
        for (int c = 0; c < `NUM_CTX; c++) begin
            for (int i = 1; i <= `NUM_SOURCES; i++) begin
                if (ctx_wr[c].claim_rd && (ctx_claim[c] == 32'(i))) begin
                    clr[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio_q  <= '0;
            pend_q  <= '0;
            line_q  <= '0;
            line_qq <= '0;
        end else begin
            line_q  <= irq_lines;
            line_qq <= line_q;
            // rising edge sets pending two cycles after the line rises
            pend_q  <= (pend_q & ~clr) | (line_q & ~line_qq);
            // held request rewrites the same value until the next access
            if (busy_req.write && sel.plic_prio && id_ok) begin
                prio_q[sel.prio_id] <= busy_req.wdata[`PRIO_W-1:0];
            end
        end
    end

    for (genvar c = 0; c < `NUM_CTX; c++) begin : g_ctx
        plic_context plic_context_i (
            .CLOCK_50  (CLOCK_50),
            .KEY0      (KEY0),
            .wr        (ctx_wr[c]),
            .pending   (pend),
            .prio      (prio_q),
            .enable    (ctx_enable[c]),
            .threshold (ctx_threshold[c]),
            .claim_id  (ctx_claim[c]),
            .irq       (irq_vec[c])
        );
    end

    // context 0 is hart 0 M-mode, context 1 is hart 0 S-mode
    assign meip = irq_vec[0];
    assign seip = irq_vec[1];

endmodule

// File: hdl/bus_response.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module bus_response (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,
    input  soc_bus_pkg::bus_req_t              busy_req,
    input  soc_bus_pkg::region_sel_t           sel,
    input  logic                               active,
    input  logic [63:0]                        ram_rdata,
    input  logic                               ram_last,
    input  logic [31:0]                        pend,
    input  logic [`PRIO_W-1:0]                 prio_rd,
    input  logic [`NUM_CTX-1:0][31:0]          ctx_enable,
    input  logic [`NUM_CTX-1:0][`PRIO_W-1:0]   ctx_threshold,
    input  logic [`NUM_CTX-1:0][31:0]          ctx_claim,
    input  logic [63:0]                        mtime,
    output logic [63:0]                        rdata,
    output logic                               read_done,
    output logic                               write_done,
    output logic [63:0]                        mtimecmp
);

    logic [63:0] rd_mux;
    logic        final_step;

    assign final_step = active && (!sel.ram || ram_last);

    // done stays low while the access is in flight
    assign read_done  = !(active && busy_req.read);
    assign write_done = !(active && busy_req.write);

    always_comb begin
        if (sel.unmapped || sel.ack_only)  rd_mux = '0;
        else if (sel.ram)                  rd_mux = ram_rdata;
        else if (sel.plic_prio)            rd_mux = 64'(prio_rd);
        else if (sel.plic_pend)            rd_mux = 64'(pend);
        else if (sel.plic_en)              rd_mux = 64'(ctx_enable[sel.ctx]);
        else if (sel.plic_thr)             rd_mux = 64'(ctx_threshold[sel.ctx]);
        else if (sel.plic_claim)           rd_mux = 64'(ctx_claim[sel.ctx]);
        else if (sel.mtime)                rd_mux = mtime;
        else if (sel.mtimecmp)             rd_mux = mtimecmp;
        else                               rd_mux = '0;
    end

    always_ff @(posedge CLOCK_50) begin
        if (final_step && busy_req.read) begin
            rdata <= rd_mux;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp <= `MTIMECMP_RESET;
        end else if (active && busy_req.write && sel.mtimecmp) begin
            mtimecmp <= busy_req.wdata;
        end
    end

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module soc_bus_top (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::bus_req_t req,
    input  logic [63:0]           mtime,
    input  logic [`NUM_SOURCES:1] irq_lines,
    output logic [63:0]           rdata,
    output logic                  read_done,
    output logic                  write_done,
    output logic [63:0]           mtimecmp,
    output logic                  meip,
    output logic                  seip
);

    soc_bus_pkg::bus_req_t                busy_req;
    soc_bus_pkg::region_sel_t             sel;
    soc_bus_pkg::plic_wr_t [`NUM_CTX-1:0] ctx_wr;
    logic                                 active;
    logic [63:0]                          ram_rdata;
    logic                                 ram_last;
    logic [31:0]                          pend;
    logic [`PRIO_W-1:0]                   prio_rd;
    logic [`NUM_CTX-1:0][31:0]            ctx_enable;
    logic [`NUM_CTX-1:0][`PRIO_W-1:0]     ctx_threshold;
    logic [`NUM_CTX-1:0][31:0]            ctx_claim;

    bus_decoder bus_decoder_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .busy_req (busy_req),
        .sel      (sel),
        .ctx_wr   (ctx_wr),
        .active   (active)
    );

    ram_port ram_port_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .busy_req  (busy_req),
        .sel_ram   (sel.ram),
        .active    (active),
        .rdata     (ram_rdata),
        .last_step (ram_last)
    );

    plic_core plic_core_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .irq_lines     (irq_lines),
        .busy_req      (busy_req),
        .sel           (sel),
        .ctx_wr        (ctx_wr),
        .pend          (pend),
        .prio_rd       (prio_rd),
        .ctx_enable    (ctx_enable),
        .ctx_threshold (ctx_threshold),
        .ctx_claim     (ctx_claim),
        .meip          (meip),
        .seip          (seip)
    );

    bus_response bus_response_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .busy_req      (busy_req),
        .sel           (sel),
        .active        (active),
        .ram_rdata     (ram_rdata),
        .ram_last      (ram_last),
        .pend          (pend),
        .prio_rd       (prio_rd),
        .ctx_enable    (ctx_enable),
        .ctx_threshold (ctx_threshold),
        .ctx_claim     (ctx_claim),
        .mtime         (mtime),
        .rdata         (rdata),
        .read_done     (read_done),
        .write_done    (write_done),
        .mtimecmp      (mtimecmp)
    );

endmodule

// File: testbench/tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module tb_soc_bus;

    localparam int          CYCLE_LIMIT   = 2000;
    localparam int          TEST_BYTES    = 32;
    localparam logic [63:0] RAM_TEST      = `RAM_BASE + 64'h100;
    localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_3000_0000;

    logic                  CLOCK_50;
    logic                  KEY0;
    soc_bus_pkg::bus_req_t req;
    logic [63:0]           mtime;
    logic [`NUM_SOURCES:1] irq_lines;
    logic [63:0]           rdata;
    logic                  read_done;
    logic                  write_done;
    logic [63:0]           mtimecmp;
    logic                  meip;
    logic                  seip;

    // little-endian byte image of the RAM window under test
    logic [7:0]            model_mem [TEST_BYTES];
    int                    cycles = 0;
    logic                  req_dbl;

    soc_bus_top soc_bus_top_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .mtime      (mtime),
        .irq_lines  (irq_lines),
        .rdata      (rdata),
        .read_done  (read_done),
        .write_done (write_done),
        .mtimecmp   (mtimecmp),
        .meip       (meip),
        .seip       (seip)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else fail_with($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                 $time, what, got, exp));
    endtask

    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_with("timeout: the tests did not finish within the cycle limit");
        end
    end

    // RAM doublewords take one extra cycle
    assign req_dbl = (req.addr >= `RAM_BASE) && (req.addr < `RAM_BASE + 64'(`RAM_WORDS * 4)) &&
                     (req.ls_type == soc_bus_pkg::LS_D);

    rd_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.read && !req_dbl |=> !read_done && write_done ##1 read_done)
        else fail_with($sformatf("** Error at %0t ns: read_done timing wrong", $time));

    rd_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.read && req_dbl |=> !read_done ##1 !read_done ##1 read_done)
        else fail_with($sformatf("** Error at %0t ns: doubleword read_done timing wrong", $time));

    wr_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.write && !req_dbl |=> !write_done && read_done ##1 write_done)
        else fail_with($sformatf("** Error at %0t ns: write_done timing wrong", $time));

    wr_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.write && req_dbl |=> !write_done ##1 !write_done ##1 write_done)
        else fail_with($sformatf("** Error at %0t ns: doubleword write_done timing wrong", $time));

    // one pulse and a wait for both done flags
    task automatic bus_access(input logic is_write, input logic [63:0] addr,
                              input logic [63:0] wdata, input soc_bus_pkg::ls_type_e t);
        req.addr    = addr;
        req.wdata   = wdata;
        req.ls_type = t;
        req.read    = !is_write;
        req.write   = is_write;
        @(posedge CLOCK_50);
        #1;
        req.read  = 1'b0;
        req.write = 1'b0;
        do begin
            @(posedge CLOCK_50);
            #1;
        end while (!(read_done && write_done));
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] wdata,
                             input soc_bus_pkg::ls_type_e t);
        bus_access(1'b1, addr, wdata, t);
    endtask

    task automatic read_check(input string what, input logic [63:0] addr,
                              input soc_bus_pkg::ls_type_e t, input logic [63:0] exp);
        bus_access(1'b0, addr, 64'd0, t);
        check_eq(what, rdata, exp);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    function automatic int type_bytes(input soc_bus_pkg::ls_type_e t);
        case (t)
            soc_bus_pkg::LS_B, soc_bus_pkg::LS_BU: return 1;
            soc_bus_pkg::LS_H, soc_bus_pkg::LS_HU: return 2;
            soc_bus_pkg::LS_W, soc_bus_pkg::LS_WU: return 4;
            default:                               return 8;
        endcase
    endfunction

    task automatic model_store(input int off, input logic [63:0] data,
                               input soc_bus_pkg::ls_type_e t);
        for (int i = 0; i < type_bytes(t); i++) begin
            model_mem[off + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [63:0] model_load(input int off, input soc_bus_pkg::ls_type_e t);
        logic [63:0] v;
        int          n;
        logic        is_signed;
        v         = '0;
        n         = type_bytes(t);
        is_signed = (t == soc_bus_pkg::LS_B) || (t == soc_bus_pkg::LS_H) ||
                    (t == soc_bus_pkg::LS_W);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_mem[off + i];
        end
        // copy the top loaded bit upward
        if (is_signed && v[8*n-1]) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic ram_test();
        soc_bus_pkg::ls_type_e st [4];
        soc_bus_pkg::ls_type_e lt [7];
        soc_bus_pkg::ls_type_e t;
        logic [63:0]           data;
        int                    off;
        int                    n;
        st = '{soc_bus_pkg::LS_B, soc_bus_pkg::LS_H, soc_bus_pkg::LS_W, soc_bus_pkg::LS_D};
        lt = '{soc_bus_pkg::LS_B, soc_bus_pkg::LS_H, soc_bus_pkg::LS_W, soc_bus_pkg::LS_D,
               soc_bus_pkg::LS_BU, soc_bus_pkg::LS_HU, soc_bus_pkg::LS_WU};
        // doublewords first so every byte is known
        for (off = 0; off < TEST_BYTES; off += 8) begin
            data = {$urandom, $urandom};
            bus_write(RAM_TEST + 64'(off), data, soc_bus_pkg::LS_D);
            model_store(off, data, soc_bus_pkg::LS_D);
        end
        repeat (30) begin
            t    = st[$urandom_range(3, 0)];
            n    = type_bytes(t);
            off  = int'($urandom_range(TEST_BYTES / n - 1, 0)) * n;
            data = {$urandom, $urandom};
            bus_write(RAM_TEST + 64'(off), data, t);
            model_store(off, data, t);
        end
        // every load type at every aligned offset
        for (int k = 0; k < 7; k++) begin
            n = type_bytes(lt[k]);
            for (off = 0; off < TEST_BYTES; off += n) begin
                read_check($sformatf("RAM %s load at +%0d", lt[k].name(), off),
                           RAM_TEST + 64'(off), lt[k], model_load(off, lt[k]));
            end
        end
    endtask

    task automatic timer_test();
        logic [63:0] data;
        data = {$urandom, $urandom};
        bus_write(`MTIMECMP_ADDR, data, soc_bus_pkg::LS_D);
        check_eq("mtimecmp port", mtimecmp, data);
        read_check("mtimecmp readback", `MTIMECMP_ADDR, soc_bus_pkg::LS_D, data);
        mtime = {$urandom, $urandom};
        read_check("mtime read", `MTIME_ADDR, soc_bus_pkg::LS_D, mtime);
        bus_write(`TLB_ADDR, 64'd1, soc_bus_pkg::LS_D);
        bus_write(`CACHEI_ADDR, 64'd1, soc_bus_pkg::LS_D);
        read_check("unmapped read", UNMAPPED_ADDR, soc_bus_pkg::LS_D, 64'd0);
    endtask

    task automatic plic_single_test();
        bus_write(`PLIC_BASE + 64'd8, 64'd3, soc_bus_pkg::LS_W);
        read_check("priority of id 2", `PLIC_BASE + 64'd8, soc_bus_pkg::LS_W, 64'd3);
        bus_write(`PLIC_ENABLE, 64'h4, soc_bus_pkg::LS_W);
        read_check("context 0 enable", `PLIC_ENABLE, soc_bus_pkg::LS_W, 64'h4);
        check_eq("meip before the edge", meip, 1'b0);
        irq_lines[2] = 1'b1;
        wait_cycles(3);
        read_check("pending after id 2 edge", `PLIC_PENDING, soc_bus_pkg::LS_W, 64'h4);
        check_eq("meip with id 2 pending", meip, 1'b1);
        read_check("context 0 claim", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd2);
        check_eq("meip after claim", meip, 1'b0);
        // line still high so no new edge
        read_check("pending after claim", `PLIC_PENDING, soc_bus_pkg::LS_W, 64'd0);
        irq_lines = '0;
    endtask

    task automatic plic_arbitration_test();
        bus_write(`PLIC_BASE + 64'd4, 64'd2, soc_bus_pkg::LS_W);
        bus_write(`PLIC_BASE + 64'd12, 64'd5, soc_bus_pkg::LS_W);
        bus_write(`PLIC_BASE + 64'd16, 64'd5, soc_bus_pkg::LS_W);
        bus_write(`PLIC_BASE + 64'd20, 64'd1, soc_bus_pkg::LS_W);
        // ids 1, 3 and 4 in context 0
        bus_write(`PLIC_ENABLE, 64'h1a, soc_bus_pkg::LS_W);
        irq_lines = 5'b01101;
        wait_cycles(3);
        read_check("pending ids 1 3 4", `PLIC_PENDING, soc_bus_pkg::LS_W, 64'h1a);
        read_check("claim with tie at priority 5", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd3);
        bus_write(`PLIC_THRESHOLD, 64'd5, soc_bus_pkg::LS_W);
        read_check("context 0 threshold", `PLIC_THRESHOLD, soc_bus_pkg::LS_W, 64'd5);
        check_eq("meip at threshold 5", meip, 1'b0);
        read_check("claim at threshold 5", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd0);
        bus_write(`PLIC_THRESHOLD, 64'd1, soc_bus_pkg::LS_W);
        read_check("claim at threshold 1", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd4);
        bus_write(`PLIC_THRESHOLD, 64'd2, soc_bus_pkg::LS_W);
        check_eq("meip with id 1 at threshold", meip, 1'b0);
        read_check("claim at threshold 2", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd0);
        bus_write(`PLIC_THRESHOLD, 64'd0, soc_bus_pkg::LS_W);
        read_check("claim of id 1", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd1);
        check_eq("meip with nothing pending", meip, 1'b0);
        irq_lines = '0;
        // context 1 takes id 5 alone
        bus_write(`PLIC_ENABLE + `PLIC_ENABLE_STRIDE, 64'h20, soc_bus_pkg::LS_W);
        read_check("context 1 enable", `PLIC_ENABLE + `PLIC_ENABLE_STRIDE,
                   soc_bus_pkg::LS_W, 64'h20);
        irq_lines[5] = 1'b1;
        wait_cycles(3);
        check_eq("seip with id 5 pending", seip, 1'b1);
        check_eq("meip with id 5 pending", meip, 1'b0);
        read_check("context 0 claim of id 5", `PLIC_CLAIM, soc_bus_pkg::LS_W, 64'd0);
        read_check("context 1 claim", `PLIC_CLAIM + `PLIC_CTX_STRIDE, soc_bus_pkg::LS_W, 64'd5);
        check_eq("seip after claim", seip, 1'b0);
        irq_lines = '0;
    endtask

    initial begin
        void'($urandom(55));
        KEY0      = 1'b0;
        req       = '0;
        mtime     = 64'h0000_0000_0000_1234;
        irq_lines = '0;
        repeat (8) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        wait_cycles(1);
        check_eq("read_done after reset", read_done, 1'b1);
        check_eq("write_done after reset", write_done, 1'b1);
        check_eq("mtimecmp after reset", mtimecmp, `MTIMECMP_RESET);
        read_check("mtimecmp readback after reset", `MTIMECMP_ADDR, soc_bus_pkg::LS_D,
                   `MTIMECMP_RESET);
        ram_test();
        timer_test();
        plic_single_test();
        plic_arbitration_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/soc_bus_pkg.sv
hdl/bus_decoder.sv
hdl/ram_port.sv
hdl/plic_context.sv
hdl/plic_core.sv
hdl/bus_response.sv
hdl/soc_bus_top.sv
testbench/tb_soc_bus.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := tb_soc_bus
RTL_TOP   := soc_bus_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
